// File: chan_macros.svh
// channelizer buffer parameters
`ifndef CHAN_MACROS_SVH
`define CHAN_MACROS_SVH

// complex word with I in the upper half
`define CH_DATA_WIDTH 32

// fft_size width for up to 2048 channels
`define CH_FFT_SIZE_WIDTH 12

// pipeline latencies in cycles
`define CH_RAM_LATENCY 3
`define CH_ADD_LATENCY 4

// output stage FIFO
`define CH_OUT_FIFO_DEPTH 16
`define CH_OUT_READY_LEVEL 6

`endif

// File: chan_data_pkg.sv
// channelizer sample data types
`include "chan_macros.svh"

package chan_data_pkg;

    // one complex sample with I upper and Q lower
    typedef logic [`CH_DATA_WIDTH-1:0] iq_t;

    // one signed I or Q component
    typedef logic signed [`CH_DATA_WIDTH/2-1:0] sample_t;

    // top word in the upper half, bottom word in the lower half
    typedef logic [2*`CH_DATA_WIDTH-1:0] iq_pair_t;

endpackage

// File: chan_ctrl_pkg.sv
// channelizer control types
`include "chan_macros.svh"

package chan_ctrl_pkg;

    // number of channels, a power of two
    typedef logic [`CH_FFT_SIZE_WIDTH-1:0] fft_size_t;

    // input or output phase index
    typedef logic [`CH_FFT_SIZE_WIDTH-2:0] phase_t;

    // address inside one half of a bank
    typedef logic [`CH_FFT_SIZE_WIDTH-3:0] ram_addr_t;

    typedef enum logic [1:0] {
        rd_idle,
        rd_bank0,
        rd_bank1
    } rd_state_t;

endpackage

// File: dp_block_read_first_ram.sv
// dual-port read-first block RAM
`timescale 1ns/10ps
`include "chan_macros.svh"

module dp_block_read_first_ram #(
    parameter int DATA_WIDTH = 32,
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  wea,
    input  logic [ADDR_WIDTH-1:0] addra,
    input  logic [ADDR_WIDTH-1:0] addrb,
    input  logic [DATA_WIDTH-1:0] dia,
    output logic [DATA_WIDTH-1:0] dob
);

    logic [DATA_WIDTH-1:0] mem [2**ADDR_WIDTH];
    logic [DATA_WIDTH-1:0] dob_pipe [`CH_RAM_LATENCY];

    always_ff @(posedge clk) begin
        if (wea) begin
            mem[addra] <= dia;
        end
    end

    // port b samples the old word on a collision
    always_ff @(posedge clk) begin
        dob_pipe[0] <= mem[addrb];
        for (int i = 1; i < `CH_RAM_LATENCY; i++) begin
            dob_pipe[i] <= dob_pipe[i-1];
        end
    end

    assign dob = dob_pipe[`CH_RAM_LATENCY-1];

endmodule

// File: output_adder.sv
// pipelined sample adder
`timescale 1ns/10ps

module output_adder (
    input  logic                   clk,
    input  chan_data_pkg::sample_t a,
    input  chan_data_pkg::sample_t d,
    output chan_data_pkg::sample_t p
);

    import chan_data_pkg::*;

    sample_t a_r;
    sample_t d_r;
    sample_t sum_r;
    sample_t sum_d;

    // operand regs, pre-add, then two output stages
    always_ff @(posedge clk) begin
        a_r   <= a;
        d_r   <= d;
        // wraps at the sample width
        sum_r <= a_r + d_r;
        sum_d <= sum_r;
        p     <= sum_d;
    end

endmodule

// File: output_count.sv
// output FIFO with phase count
`timescale 1ns/10ps
`include "chan_macros.svh"

module output_count (
    input  logic                  clk,
    input  logic                  sync_reset,
    input  logic                  s_axis_tvalid,
    input  chan_data_pkg::iq_t    s_axis_tdata,
    input  logic                  start_sig,
    input  chan_ctrl_pkg::phase_t cnt_limit,
    output logic                  s_axis_tready,
    output logic                  m_axis_tvalid,
    output chan_data_pkg::iq_t    m_axis_tdata,
    output logic                  m_axis_final_cnt,
    output chan_ctrl_pkg::phase_t count,
    input  logic                  m_axis_tready
);

    import chan_data_pkg::*;
    import chan_ctrl_pkg::*;

    localparam int PTR_W = $clog2(`CH_OUT_FIFO_DEPTH);

    iq_t    data_mem  [`CH_OUT_FIFO_DEPTH];
    phase_t phase_mem [`CH_OUT_FIFO_DEPTH];
    logic [`CH_OUT_FIFO_DEPTH-1:0] final_mem;

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   fill;
    phase_t           cnt;
    phase_t           push_idx;
    logic             pop;

    // start of a frame restarts the index at zero
    assign push_idx = start_sig ? '0 : cnt;
    assign pop      = m_axis_tvalid && m_axis_tready;

    assign m_axis_tvalid    = (fill != '0);
    assign m_axis_tdata     = data_mem[rd_ptr];
    assign count            = phase_mem[rd_ptr];
    assign m_axis_final_cnt = m_axis_tvalid && final_mem[rd_ptr];

    // headroom for the reads still in the pipeline
    assign s_axis_tready = (fill <= `CH_OUT_READY_LEVEL);

    always_ff @(posedge clk) begin
        if (s_axis_tvalid) begin
            data_mem[wr_ptr]  <= s_axis_tdata;
            phase_mem[wr_ptr] <= push_idx;
            final_mem[wr_ptr] <= (push_idx == cnt_limit);
        end
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
            cnt    <= '0;
        end else begin
            if (s_axis_tvalid) begin
                wr_ptr <= wr_ptr + 1'b1;
                cnt    <= push_idx + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({s_axis_tvalid, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

// File: output_buffer.sv
// channelizer output buffer
`timescale 1ns/10ps
`include "chan_macros.svh"

module output_buffer (
    input  logic                     clk,
    input  logic                     sync_reset,
    input  logic                     s_axis_tvalid,
    input  chan_data_pkg::iq_t       s_axis_tdata,
    input  logic                     s_axis_tlast,
    output logic                     s_axis_tready,
    input  chan_ctrl_pkg::fft_size_t fft_size,
    input  chan_ctrl_pkg::phase_t    phase_in,
    output chan_ctrl_pkg::phase_t    phase_out,
    output logic                     m_axis_tvalid,
    output chan_data_pkg::iq_t       m_axis_tdata,
    output logic                     m_axis_final_cnt,
    input  logic                     m_axis_tready
);

    import chan_data_pkg::*;
    import chan_ctrl_pkg::*;

    localparam int AW = `CH_FFT_SIZE_WIDTH - 2;
    localparam int SW = `CH_DATA_WIDTH / 2;
    localparam int RL = `CH_RAM_LATENCY;
    localparam int AL = `CH_ADD_LATENCY;

    phase_t    half_size;
    phase_t    last_phase;
    phase_t    cnt_limit;
    ram_addr_t addr_mask;
    ram_addr_t rd_stop;

    // write pointers carry a wrap bit above the address
    logic        wr_side;
    logic [AW:0] wr_ptr [2];
    logic [1:0]  we;
    logic        bottom_active;
    iq_t         wr_data;

    // read side
    rd_state_t   state;
    logic        rd_side;
    logic [AW:0] rd_ptr [2];
    logic [1:0]  rd_finish;
    logic [1:0]  full;
    logic        rd_en;
    logic        start_sig;
    logic        rd_tready;

    logic [RL-1:0] rd_en_d;
    logic [RL-1:0] rd_side_d;
    logic [RL-1:0] start_d;
    iq_t           rd_top [2];
    iq_t           rd_bot [2];
    iq_pair_t      rd_tdata;
    logic          rd_tvalid;
    logic          rd_start;
    logic [AL-1:0] rd_tvalid_d;
    logic [AL-1:0] rd_start_d;
    sample_t       sum_i;
    sample_t       sum_q;

    // limits derived from fft_size
    always_ff @(posedge clk) begin
        half_size  <= fft_size[`CH_FFT_SIZE_WIDTH-1:1];
        last_phase <= phase_t'(fft_size - 1'b1);
        cnt_limit  <= fft_size[`CH_FFT_SIZE_WIDTH-1:1] - 1'b1;
    end

    assign addr_mask = cnt_limit[AW-1:0];
    assign rd_stop   = addr_mask - 1'b1;

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            full[b] = (wr_ptr[b][AW] != rd_ptr[b][AW]) && !rd_finish[b];
        end
    end

    // frame end comes from phase_in and not from tlast
    assign s_axis_tready = s_axis_tvalid && !full[wr_side];

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            wr_side       <= 1'b0;
            wr_ptr[0]     <= '0;
            wr_ptr[1]     <= '0;
            we            <= 2'b00;
            bottom_active <= 1'b0;
        end else begin
            we <= 2'b00;
            if (s_axis_tready) begin
                we[wr_side]     <= 1'b1;
                wr_ptr[wr_side] <= {phase_in == last_phase, phase_in[AW-1:0] & addr_mask};
                if (phase_in == last_phase) begin
                    wr_side <= ~wr_side;
                end
                // upper phases go to the bottom half
                if (phase_in == '0) begin
                    bottom_active <= 1'b0;
                end else if (phase_in == half_size) begin
                    bottom_active <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        wr_data <= s_axis_tdata;
    end

    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            state     <= rd_idle;
            rd_side   <= 1'b1;
            rd_ptr[0] <= '0;
            rd_ptr[1] <= '0;
            rd_finish <= 2'b00;
            rd_en     <= 1'b0;
            start_sig <= 1'b0;
        end else begin
            rd_en     <= 1'b0;
            start_sig <= 1'b0;
            if (s_axis_tready) begin
                rd_finish[wr_side] <= 1'b0;
            end
            case (state)
                rd_idle: begin
                    // banks are drained in turn
                    if (rd_tready && full[~rd_side]) begin
                        rd_side          <= ~rd_side;
                        rd_ptr[~rd_side] <= '0;
                        rd_en            <= 1'b1;
                        start_sig        <= 1'b1;
                        state            <= rd_side ? rd_bank0 : rd_bank1;
                    end
                end
                rd_bank0, rd_bank1: begin
                    if (rd_tready) begin
                        rd_en           <= 1'b1;
                        rd_ptr[rd_side] <= rd_ptr[rd_side] + 1'b1;
                        if (rd_ptr[rd_side][AW-1:0] == rd_stop) begin
                            rd_finish[rd_side] <= 1'b1;
                            state              <= rd_idle;
                        end
                    end
                end
                default: state <= rd_idle;
            endcase
        end
    end

    // realign controls with RAM data, then with the adder output
    always_ff @(posedge clk or posedge sync_reset) begin
        if (sync_reset) begin
            rd_en_d     <= '0;
            rd_side_d   <= '0;
            start_d     <= '0;
            rd_tvalid   <= 1'b0;
            rd_start    <= 1'b0;
            rd_tvalid_d <= '0;
            rd_start_d  <= '0;
        end else begin
            rd_en_d     <= {rd_en_d[RL-2:0], rd_en};
            rd_side_d   <= {rd_side_d[RL-2:0], rd_side};
            start_d     <= {start_d[RL-2:0], start_sig};
            rd_tvalid   <= rd_en_d[RL-1];
            rd_start    <= start_d[RL-1];
            rd_tvalid_d <= {rd_tvalid_d[AL-2:0], rd_tvalid};
            rd_start_d  <= {rd_start_d[AL-2:0], rd_start};
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en_d[RL-1]) begin
            rd_tdata <= rd_side_d[RL-1] ? {rd_top[1], rd_bot[1]} : {rd_top[0], rd_bot[0]};
        end
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        dp_block_read_first_ram #(
            .DATA_WIDTH(`CH_DATA_WIDTH),
            .ADDR_WIDTH(AW)
        ) u_ram_top (
            .clk   (clk),
            .wea   (we[b] & ~bottom_active),
            .addra (wr_ptr[b][AW-1:0]),
            .addrb (rd_ptr[b][AW-1:0]),
            .dia   (wr_data),
            .dob   (rd_top[b])
        );

        dp_block_read_first_ram #(
            .DATA_WIDTH(`CH_DATA_WIDTH),
            .ADDR_WIDTH(AW)
        ) u_ram_bottom (
            .clk   (clk),
            .wea   (we[b] & bottom_active),
            .addra (wr_ptr[b][AW-1:0]),
            .addrb (rd_ptr[b][AW-1:0]),
            .dia   (wr_data),
            .dob   (rd_bot[b])
        );
    end

    // fold adds top and bottom per component
    output_adder u_add_i (
        .clk (clk),
        .a   (sample_t'(rd_tdata[4*SW-1:3*SW])),
        .d   (sample_t'(rd_tdata[2*SW-1:SW])),
        .p   (sum_i)
    );

    output_adder u_add_q (
        .clk (clk),
        .a   (sample_t'(rd_tdata[3*SW-1:2*SW])),
        .d   (sample_t'(rd_tdata[SW-1:0])),
        .p   (sum_q)
    );

    output_count u_out_count (
        .clk              (clk),
        .sync_reset       (sync_reset),
        .s_axis_tvalid    (rd_tvalid_d[AL-1]),
        .s_axis_tdata     ({sum_i, sum_q}),
        .start_sig        (rd_start_d[AL-1]),
        .cnt_limit        (cnt_limit),
        .s_axis_tready    (rd_tready),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_final_cnt (m_axis_final_cnt),
        .count            (phase_out),
        .m_axis_tready    (m_axis_tready)
    );

endmodule

// File: tb_output_buffer.sv
// output buffer testbench
`timescale 1ns/10ps

module tb_output_buffer;

    import chan_data_pkg::*;
    import chan_ctrl_pkg::*;

    localparam int TIMEOUT = 2000;

    logic      clk;
    logic      sync_reset;
    logic      s_axis_tvalid;
    iq_t       s_axis_tdata;
    logic      s_axis_tlast;
    logic      s_axis_tready;
    fft_size_t fft_size;
    phase_t    phase_in;
    phase_t    phase_out;
    logic      m_axis_tvalid;
    iq_t       m_axis_tdata;
    logic      m_axis_final_cnt;
    logic      m_axis_tready;

    logic [31:0] lfsr_state;
    int          error_count;
    logic        sink_random;
    logic        sink_hold;
    iq_t         exp_data [$];
    phase_t      exp_phase [$];
    logic        exp_final [$];

    output_buffer dut_i (
        .clk              (clk),
        .sync_reset       (sync_reset),
        .s_axis_tvalid    (s_axis_tvalid),
        .s_axis_tdata     (s_axis_tdata),
        .s_axis_tlast     (s_axis_tlast),
        .s_axis_tready    (s_axis_tready),
        .fft_size         (fft_size),
        .phase_in         (phase_in),
        .phase_out        (phase_out),
        .m_axis_tvalid    (m_axis_tvalid),
        .m_axis_tdata     (m_axis_tdata),
        .m_axis_final_cnt (m_axis_final_cnt),
        .m_axis_tready    (m_axis_tready)
    );

    always #2 clk = ~clk;

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic check_iq(input string name, input iq_t expected, input iq_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_phase(input string name, input phase_t expected, input phase_t actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        error_count++;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #0.5;
        sync_reset    = 1'b1;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        repeat (3) @(posedge clk);
        #0.5;
        sync_reset = 1'b0;
        exp_data.delete();
        exp_phase.delete();
        exp_final.delete();
    endtask

    // DUT size limits are registered
    task automatic set_size(input int n);
        @(posedge clk);
        #0.5;
        fft_size = fft_size_t'(n);
        repeat (2) @(posedge clk);
    endtask

    // back-to-back frames of n words with fold sums queued first
    task automatic send_frames(input int frames, input int n);
        iq_t         frame [];
        logic [31:0] r;
        sample_t     s_i;
        sample_t     s_q;
        int          waited;
        frame = new[n];
        for (int f = 0; f < frames; f++) begin
            for (int p = 0; p < n; p++) begin
                draw_bits(32, r);
                frame[p] = r;
            end
            for (int k = 0; k < n / 2; k++) begin
                s_i = sample_t'(frame[k][31:16]) + sample_t'(frame[k + n / 2][31:16]);
                s_q = sample_t'(frame[k][15:0]) + sample_t'(frame[k + n / 2][15:0]);
                exp_data.push_back({s_i, s_q});
                exp_phase.push_back(phase_t'(k));
                exp_final.push_back(k == n / 2 - 1);
            end
            for (int p = 0; p < n; p++) begin
                @(posedge clk);
                #0.5;
                s_axis_tvalid = 1'b1;
                s_axis_tdata  = frame[p];
                phase_in      = phase_t'(p);
                s_axis_tlast  = (p == n - 1);
                waited = 0;
                @(negedge clk);
                while (!s_axis_tready && waited < TIMEOUT) begin
                    waited++;
                    @(negedge clk);
                end
                if (waited >= TIMEOUT) begin
                    report_timeout("s_axis_tready");
                end
            end
        end
        @(posedge clk);
        #0.5;
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    // pulls count words and checks data, index and flag in order
    task automatic collect(input int count);
        int          got;
        int          idle;
        logic        held;
        iq_t         held_data;
        logic [31:0] r;
        got  = 0;
        idle = 0;
        held = 1'b0;
        held_data = '0;
        while (got < count && idle < TIMEOUT) begin
            @(posedge clk);
            #0.5;
            r = 32'd1;
            if (sink_random) begin
                draw_bits(1, r);
            end
            m_axis_tready = !sink_hold && r[0];
            @(negedge clk);
            // a stalled word must not change
            if (held) begin
                check_bit("m_axis_tvalid", 1'b1, m_axis_tvalid);
                check_iq("m_axis_tdata", held_data, m_axis_tdata);
            end
            held      = m_axis_tvalid && !m_axis_tready;
            held_data = m_axis_tdata;
            if (!sink_hold) begin
                idle++;
            end
            if (m_axis_tvalid && m_axis_tready) begin
                idle = 0;
                got++;
                if (exp_data.size() == 0) begin
                    $display("an output word arrived at %0t with none expected", $time);
                    error_count++;
                end else begin
                    check_iq("m_axis_tdata", exp_data.pop_front(), m_axis_tdata);
                    check_phase("phase_out", exp_phase.pop_front(), phase_out);
                    check_bit("m_axis_final_cnt", exp_final.pop_front(), m_axis_final_cnt);
                end
            end
        end
        if (got < count) begin
            report_timeout("output word");
        end
        @(posedge clk);
        #0.5;
        m_axis_tready = 1'b0;
    endtask

    task automatic release_after_stall();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!(s_axis_tvalid && !s_axis_tready) && waited < TIMEOUT) begin
            waited++;
            @(negedge clk);
        end
        if (waited >= TIMEOUT) begin
            $display("s_axis_tready never dropped while the sink was stalled");
            error_count++;
        end
        repeat (20) @(posedge clk);
        sink_hold = 1'b0;
    endtask

    // nothing extra should come out once a test is done
    task automatic check_drained();
        repeat (20) @(posedge clk);
        @(negedge clk);
        check_bit("m_axis_tvalid", 1'b0, m_axis_tvalid);
    endtask

    task automatic test_fold_and_resize();
        apply_reset();
        set_size(16);
        fork
            send_frames(1, 16);
            collect(8);
        join
        apply_reset();
        set_size(4);
        fork
            send_frames(1, 4);
            collect(2);
        join
        set_size(64);
        fork
            send_frames(1, 64);
            collect(32);
        join
        check_drained();
    endtask

    task automatic test_ping_pong();
        apply_reset();
        set_size(8);
        fork
            send_frames(3, 8);
            collect(12);
        join
        check_drained();
    endtask

    task automatic test_back_pressure();
        apply_reset();
        set_size(16);
        sink_random = 1'b1;
        fork
            send_frames(3, 16);
            collect(24);
        join
        sink_random = 1'b0;
        check_drained();
    endtask

    // both banks fill while the FIFO is stuck
    task automatic test_input_stall();
        apply_reset();
        set_size(16);
        sink_hold = 1'b1;
        fork
            send_frames(4, 16);
            release_after_stall();
            collect(32);
        join
        check_drained();
    endtask

    initial begin
        clk           = 1'b0;
        sync_reset    = 1'b1;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tlast  = 1'b0;
        fft_size      = fft_size_t'(16);
        phase_in      = '0;
        m_axis_tready = 1'b0;
        lfsr_state    = 32'hb816;
        error_count   = 0;
        sink_random   = 1'b0;
        sink_hold     = 1'b0;
        test_fold_and_resize();
        test_ping_pong();
        test_back_pressure();
        test_input_stall();
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: verilog.f
+incdir+.
chan_data_pkg.sv
chan_ctrl_pkg.sv
dp_block_read_first_ram.sv
output_adder.sv
output_count.sv
output_buffer.sv
tb_output_buffer.sv

// File: Makefile
# Verilator build and run for the channelizer output buffer

VERILATOR ?= verilator
TOP       ?= tb_output_buffer
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
